//--- hdl/frontend_pkg.sv
package frontend_pkg;

  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // one instruction word, read as 3R register format or as 26-bit offset format
  typedef union packed {
    struct packed {
      logic [16:0] opcode17;
      logic [4:0]  rk;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } reg_fmt;
    struct packed {
      logic [5:0]  opcode6;
      logic [25:0] offs26;
    } imm_fmt;
  } inst_word_u;

  typedef enum logic [2:0] {
    OP_ALU_R,
    OP_ALU_I,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_JUMP_LINK,
    OP_IDLE,
    OP_INVALID
  } op_class_e;

  // full 17-bit opcodes
  localparam logic [16:0] OPC_ADD_W  = 17'h00020;
  localparam logic [16:0] OPC_SUB_W  = 17'h00022;
  localparam logic [16:0] OPC_IDLE   = 17'h00c91;
  // 2ri12 group, top 10 bits only
  localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
  localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
  localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
  // branch group, top 6 bits
  localparam logic [5:0]  OPC_B      = 6'h14;
  localparam logic [5:0]  OPC_BL     = 6'h15;
  localparam logic [5:0]  OPC_BEQ    = 6'h16;

  // register select codes
  localparam logic [1:0] R0_NONE = 2'd0;
  localparam logic [1:0] R0_RK   = 2'd1;
  localparam logic [1:0] R0_RD   = 2'd2;
  localparam logic [1:0] R1_NONE = 2'd0;
  localparam logic [1:0] R1_RJ   = 2'd1;
  localparam logic [1:0] W_NONE  = 2'd0;
  localparam logic [1:0] W_RD    = 2'd1;
  localparam logic [1:0] W_LINK  = 2'd2;

endpackage

//--- hdl/fetch_unit.sv
module fetch_unit #(
  parameter logic [31:0] RESET_PC = frontend_pkg::RESET_PC
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        halt_i,
  input  logic        kill_i,
  input  logic        load_pc_i,
  input  logic [31:0] load_pc_val_i,
  input  logic        queue_full_i,
  output logic        bus_busy_o,
  output logic        push_o,
  output logic [31:0] push_data_o,
  output logic [31:0] push_pc_o,
  output logic        wb_cyc_o,
  output logic        wb_stb_o,
  output logic        wb_we_o,
  output logic [31:0] wb_adr_o,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack_i
);

  logic [31:0] pc_q;
  logic        cyc_q;
  logic        can_start;
  logic        done;

  // a killed word means the pc gets reloaded next cycle, so no back-to-back read
  assign can_start = !halt_i && !queue_full_i && !kill_i;
  assign done      = cyc_q && wb_ack_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
    end else if (!cyc_q || wb_ack_i) begin
      cyc_q <= can_start;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (!cyc_q && load_pc_i) begin
      pc_q <= load_pc_val_i;
    end else if (done && !kill_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // address comes straight from the pc, held for the whole cycle
  assign wb_cyc_o    = cyc_q;
  assign wb_stb_o    = cyc_q;
  assign wb_we_o     = 1'b0;
  assign wb_adr_o    = pc_q;
  assign bus_busy_o  = cyc_q;

  assign push_o      = done && !kill_i;
  assign push_data_o = wb_dat_i;
  assign push_pc_o   = pc_q;

endmodule

//--- hdl/frontend_ctrl.sv
module frontend_ctrl (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_pc_i,
  input  logic        wait_i,
  input  logic        int_i,
  input  logic        bus_busy_i,
  input  logic        wb_ack_i,
  output logic        halt_o,
  output logic        kill_o,
  output logic        flush_o,
  output logic        load_pc_o,
  output logic [31:0] load_pc_val_o
);

  logic        idle_q;
  logic        kill_q;
  logic        load_q;
  logic [31:0] target_q;
  logic        late_redirect;

  // redirect with a read still open
  assign late_redirect = redirect_i && bus_busy_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_q <= 1'b0;
      kill_q <= 1'b0;
      load_q <= 1'b0;
    end else begin
      if (wait_i && !int_i) begin
        idle_q <= 1'b1;
      end else if (int_i) begin
        idle_q <= 1'b0;
      end
      kill_q <= (kill_q || late_redirect) && !wb_ack_i;
      load_q <= (kill_q || late_redirect) && wb_ack_i;
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i) begin
      target_q <= redirect_pc_i;
    end
  end

  assign halt_o        = idle_q;
  assign flush_o       = redirect_i;
  assign kill_o        = kill_q || late_redirect;
  // a fresh redirect wins over one still waiting for its load
  assign load_pc_o     = load_q || (redirect_i && !bus_busy_i);
  assign load_pc_val_o = redirect_i ? redirect_pc_i : target_q;

endmodule

//--- hdl/inst_queue.sv
module inst_queue #(
  parameter int QUEUE_DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        push_i,
  input  logic [63:0] push_data_i,
  output logic        full_o,
  output logic [1:0]  rd_valid_o,
  output logic [63:0] rd_data0_o,
  output logic [63:0] rd_data1_o,
  input  logic [1:0]  pop_num_i
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [63:0]      mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] rd_ptr_nx;
  logic [PTR_W:0]   count_q;

  assign rd_ptr_nx = rd_ptr_q + 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop_num_i);
      count_q  <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop_num_i);
    end
  end

  // a push during flush is dropped
  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // thermometer valid, head then next
  assign rd_valid_o = {count_q[PTR_W:1] != '0, count_q != '0};
  assign rd_data0_o = mem[rd_ptr_q];
  assign rd_data1_o = mem[rd_ptr_nx];

  // last free entry is kept for the word still on the bus
  assign full_o = count_q >= (PTR_W+1)'(QUEUE_DEPTH - 1);

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
  input  frontend_pkg::inst_word_u inst_i,
  output frontend_pkg::op_class_e  class_o,
  output logic [4:0]               r0_o,
  output logic [4:0]               r1_o,
  output logic [4:0]               w_o,
  output logic [25:0]              imm_o
);

  import frontend_pkg::*;

  logic [1:0] r0_sel;
  logic [1:0] r1_sel;
  logic [1:0] w_sel;

  always_comb begin
    class_o = OP_INVALID;
    r0_sel  = R0_NONE;
    r1_sel  = R1_NONE;
    w_sel   = W_NONE;
    if (inst_i.reg_fmt.opcode17 == OPC_ADD_W || inst_i.reg_fmt.opcode17 == OPC_SUB_W) begin
      class_o = OP_ALU_R;
      r0_sel  = R0_RK;
      r1_sel  = R1_RJ;
      w_sel   = W_RD;
    end else if (inst_i.reg_fmt.opcode17 == OPC_IDLE) begin
      class_o = OP_IDLE;
    end else if (inst_i.reg_fmt.opcode17[16:7] == OPC_ADDI_W) begin
      class_o = OP_ALU_I;
      r1_sel  = R1_RJ;
      w_sel   = W_RD;
    end else if (inst_i.reg_fmt.opcode17[16:7] == OPC_LD_W) begin
      class_o = OP_LOAD;
      r1_sel  = R1_RJ;
      w_sel   = W_RD;
    end else if (inst_i.reg_fmt.opcode17[16:7] == OPC_ST_W) begin
      // store data sits in rd
      class_o = OP_STORE;
      r0_sel  = R0_RD;
      r1_sel  = R1_RJ;
    end else if (inst_i.imm_fmt.opcode6 == OPC_BEQ) begin
      class_o = OP_BRANCH;
      r0_sel  = R0_RD;
      r1_sel  = R1_RJ;
    end else if (inst_i.imm_fmt.opcode6 == OPC_B) begin
      class_o = OP_BRANCH;
    end else if (inst_i.imm_fmt.opcode6 == OPC_BL) begin
      class_o = OP_JUMP_LINK;
      w_sel   = W_LINK;
    end
  end

  // resolve select codes to register numbers
  always_comb begin
    case (r0_sel)
      R0_RK:   r0_o = inst_i.reg_fmt.rk;
      R0_RD:   r0_o = inst_i.reg_fmt.rd;
      default: r0_o = 5'd0;
    endcase
    r1_o = (r1_sel == R1_RJ) ? inst_i.reg_fmt.rj : 5'd0;
    case (w_sel)
      W_RD:    w_o = inst_i.reg_fmt.rd;
      W_LINK:  w_o = 5'd1;
      default: w_o = 5'd0;
    endcase
  end

  assign imm_o = inst_i.imm_fmt.offs26;

endmodule

//--- hdl/issue_buffer.sv
module issue_buffer (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    flush_i,
  input  logic [1:0]              dec_valid_i,
  input  frontend_pkg::op_class_e dec0_class_i,
  input  logic [4:0]              dec0_r0_i,
  input  logic [4:0]              dec0_r1_i,
  input  logic [4:0]              dec0_w_i,
  input  logic [25:0]             dec0_imm_i,
  input  logic [31:0]             dec0_pc_i,
  input  frontend_pkg::op_class_e dec1_class_i,
  input  logic [4:0]              dec1_r0_i,
  input  logic [4:0]              dec1_r1_i,
  input  logic [4:0]              dec1_w_i,
  input  logic [25:0]             dec1_imm_i,
  input  logic [31:0]             dec1_pc_i,
  output logic [1:0]              pop_num_o,
  input  logic [1:0]              issue_i,
  output logic [1:0]              issue_valid_o,
  output frontend_pkg::op_class_e issue0_class_o,
  output logic [4:0]              issue0_r0_o,
  output logic [4:0]              issue0_r1_o,
  output logic [4:0]              issue0_w_o,
  output logic [25:0]             issue0_imm_o,
  output logic [31:0]             issue0_pc_o,
  output frontend_pkg::op_class_e issue1_class_o,
  output logic [4:0]              issue1_r0_o,
  output logic [4:0]              issue1_r1_o,
  output logic [4:0]              issue1_w_o,
  output logic [25:0]             issue1_imm_o,
  output logic [31:0]             issue1_pc_o
);

  import frontend_pkg::*;

  // slot layout: class, r0, r1, w, imm, pc
  logic [1:0][75:0] dec_pack;
  logic [1:0][75:0] slot_q;
  logic [1:0][75:0] slot_n;
  logic [1:0]       valid_q;
  logic [1:0]       issued;
  logic [1:0]       n_valid;
  logic [1:0]       n_issue;
  logic [1:0]       n_keep;
  logic [1:0]       n_dec;
  logic [1:0]       n_room;
  logic [1:0]       n_fill;
  logic [1:0]       n_total;

  assign dec_pack[0] = {dec0_class_i, dec0_r0_i, dec0_r1_i, dec0_w_i, dec0_imm_i, dec0_pc_i};
  assign dec_pack[1] = {dec1_class_i, dec1_r0_i, dec1_r1_i, dec1_w_i, dec1_imm_i, dec1_pc_i};

  // the back end can only take slots that hold something
  assign issued  = issue_i & valid_q;
  assign n_valid = 2'(valid_q[0]) + 2'(valid_q[1]);
  assign n_issue = 2'(issued[0]) + 2'(issued[1]);
  assign n_dec   = 2'(dec_valid_i[0]) + 2'(dec_valid_i[1]);
  assign n_keep  = n_valid - n_issue;
  assign n_room  = 2'd2 - n_keep;
  assign n_fill  = (n_dec < n_room) ? n_dec : n_room;
  assign n_total = n_keep + n_fill;

  assign pop_num_o = n_fill;

  // survivors shift down first, decoded entries fill behind them
  always_comb begin
    slot_n[0] = (n_keep != 2'd0) ? slot_q[n_issue[0]] : dec_pack[0];
    if (n_keep == 2'd2) begin
      slot_n[1] = slot_q[1];
    end else if (n_keep == 2'd1) begin
      slot_n[1] = dec_pack[0];
    end else begin
      slot_n[1] = dec_pack[1];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= {n_total[1], n_total != 2'd0};
    end
  end

  always_ff @(posedge clk) begin
    slot_q <= slot_n;
  end

  assign issue_valid_o  = valid_q;
  assign issue0_class_o = op_class_e'(slot_q[0][75:73]);
  assign issue1_class_o = op_class_e'(slot_q[1][75:73]);
  assign {issue0_r0_o, issue0_r1_o, issue0_w_o, issue0_imm_o, issue0_pc_o} = slot_q[0][72:0];
  assign {issue1_r0_o, issue1_r1_o, issue1_w_o, issue1_imm_o, issue1_pc_o} = slot_q[1][72:0];

endmodule

//--- hdl/core_frontend.sv
module core_frontend #(
  parameter logic [31:0] RESET_PC    = frontend_pkg::RESET_PC,
  parameter int          QUEUE_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic                    wb_we_o,
  output logic [31:0]             wb_adr_o,
  input  logic [31:0]             wb_dat_i,
  input  logic                    wb_ack_i,
  input  logic                    redirect_i,
  input  logic [31:0]             redirect_pc_i,
  input  logic                    wait_i,
  input  logic                    int_i,
  input  logic [1:0]              issue_i,
  output logic [1:0]              issue_valid_o,
  output frontend_pkg::op_class_e issue0_class_o,
  output logic [4:0]              issue0_r0_o,
  output logic [4:0]              issue0_r1_o,
  output logic [4:0]              issue0_w_o,
  output logic [25:0]             issue0_imm_o,
  output logic [31:0]             issue0_pc_o,
  output frontend_pkg::op_class_e issue1_class_o,
  output logic [4:0]              issue1_r0_o,
  output logic [4:0]              issue1_r1_o,
  output logic [4:0]              issue1_w_o,
  output logic [25:0]             issue1_imm_o,
  output logic [31:0]             issue1_pc_o
);

  import frontend_pkg::*;

  logic        halt;
  logic        kill;
  logic        flush;
  logic        load_pc;
  logic [31:0] load_pc_val;
  logic        bus_busy;
  logic        queue_full;
  logic        push;
  logic [31:0] push_data;
  logic [31:0] push_pc;
  logic [1:0]  q_valid;
  logic [63:0] q_data0;
  logic [63:0] q_data1;
  logic [1:0]  pop_num;
  op_class_e   dec0_class;
  op_class_e   dec1_class;
  logic [4:0]  dec0_r0;
  logic [4:0]  dec0_r1;
  logic [4:0]  dec0_w;
  logic [4:0]  dec1_r0;
  logic [4:0]  dec1_r1;
  logic [4:0]  dec1_w;
  logic [25:0] dec0_imm;
  logic [25:0] dec1_imm;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n(rst_n),
    .halt_i(halt), .kill_i(kill), .load_pc_i(load_pc), .load_pc_val_i(load_pc_val),
    .queue_full_i(queue_full), .bus_busy_o(bus_busy),
    .push_o(push), .push_data_o(push_data), .push_pc_o(push_pc),
    .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_adr_o(wb_adr_o),
    .wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i)
  );

  frontend_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
    .wait_i(wait_i), .int_i(int_i), .bus_busy_i(bus_busy), .wb_ack_i(wb_ack_i),
    .halt_o(halt), .kill_o(kill), .flush_o(flush),
    .load_pc_o(load_pc), .load_pc_val_o(load_pc_val)
  );

  // queue entries carry the pc in the upper half
  inst_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .clk(clk), .rst_n(rst_n), .flush_i(flush),
    .push_i(push), .push_data_i({push_pc, push_data}), .full_o(queue_full),
    .rd_valid_o(q_valid), .rd_data0_o(q_data0), .rd_data1_o(q_data1), .pop_num_i(pop_num)
  );

  inst_decoder u_dec0 (
    .inst_i(q_data0[31:0]), .class_o(dec0_class),
    .r0_o(dec0_r0), .r1_o(dec0_r1), .w_o(dec0_w), .imm_o(dec0_imm)
  );

  inst_decoder u_dec1 (
    .inst_i(q_data1[31:0]), .class_o(dec1_class),
    .r0_o(dec1_r0), .r1_o(dec1_r1), .w_o(dec1_w), .imm_o(dec1_imm)
  );

  issue_buffer u_issue (
    .clk(clk), .rst_n(rst_n), .flush_i(flush), .dec_valid_i(q_valid),
    .dec0_class_i(dec0_class), .dec0_r0_i(dec0_r0), .dec0_r1_i(dec0_r1),
    .dec0_w_i(dec0_w), .dec0_imm_i(dec0_imm), .dec0_pc_i(q_data0[63:32]),
    .dec1_class_i(dec1_class), .dec1_r0_i(dec1_r0), .dec1_r1_i(dec1_r1),
    .dec1_w_i(dec1_w), .dec1_imm_i(dec1_imm), .dec1_pc_i(q_data1[63:32]),
    .pop_num_o(pop_num), .issue_i(issue_i), .issue_valid_o(issue_valid_o),
    .issue0_class_o(issue0_class_o), .issue0_r0_o(issue0_r0_o), .issue0_r1_o(issue0_r1_o),
    .issue0_w_o(issue0_w_o), .issue0_imm_o(issue0_imm_o), .issue0_pc_o(issue0_pc_o),
    .issue1_class_o(issue1_class_o), .issue1_r0_o(issue1_r0_o), .issue1_r1_o(issue1_r1_o),
    .issue1_w_o(issue1_w_o), .issue1_imm_o(issue1_imm_o), .issue1_pc_o(issue1_pc_o)
  );

endmodule

//--- verification/core_frontend_checker.sv
module core_frontend_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        wb_cyc_o,
  input logic        wb_stb_o,
  input logic [31:0] wb_adr_o,
  input logic        wb_ack_i,
  input logic [1:0]  issue_valid_o,
  input logic        halt_i
);
  timeunit 1ns;
  timeprecision 100ps;

  assert property (@(posedge clk) disable iff (!rst_n) wb_stb_o |-> wb_cyc_o)
    else $error("stb high without cyc");

  // address held until the cycle is acked
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_cyc_o && !wb_ack_i |=> $stable(wb_adr_o))
    else $error("address changed during an open read");

  assert property (@(posedge clk) disable iff (!rst_n) issue_valid_o != 2'b10)
    else $error("issue_valid is not a thermometer code");

  assert property (@(posedge clk) disable iff (!rst_n)
    halt_i && (!wb_cyc_o || wb_ack_i) |=> !wb_cyc_o)
    else $error("read started while idle");

endmodule

bind core_frontend core_frontend_checker u_checker (
  .clk(clk), .rst_n(rst_n), .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
  .wb_ack_i(wb_ack_i), .issue_valid_o(issue_valid_o), .halt_i(halt)
);

//--- verification/core_frontend_tb.sv
module core_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import frontend_pkg::*;

  localparam int N          = 22;
  localparam int EXP_ISSUED = 19;
  localparam int TIMEOUT    = 40 * N + 200;
  localparam int HOLD_LEN   = 30;
  localparam logic [1:0] EV_NONE  = 2'd0;
  localparam logic [1:0] EV_REDIR = 2'd1;
  localparam logic [1:0] EV_IDLE  = 2'd2;
  localparam int PH_RUN      = 0;
  localparam int PH_REDIR    = 1;
  localparam int PH_IDLE_REQ = 2;
  localparam int PH_DRAIN    = 3;
  localparam int PH_HOLD     = 4;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        wait_i;
  logic        int_i;
  logic [1:0]  issue_i;
  logic [1:0]  issue_valid_o;
  op_class_e   issue0_class_o;
  op_class_e   issue1_class_o;
  logic [4:0]  issue0_r0_o;
  logic [4:0]  issue0_r1_o;
  logic [4:0]  issue0_w_o;
  logic [4:0]  issue1_r0_o;
  logic [4:0]  issue1_r1_o;
  logic [4:0]  issue1_w_o;
  logic [25:0] issue0_imm_o;
  logic [25:0] issue1_imm_o;
  logic [31:0] issue0_pc_o;
  logic [31:0] issue1_pc_o;

  // stimulus table, one row per word at RESET_PC + 4 * row
  logic [31:0] t_word [N];
  op_class_e   t_class [N];
  logic [4:0]  t_r0 [N];
  logic [4:0]  t_r1 [N];
  logic [4:0]  t_w [N];
  logic [1:0]  t_ev [N];
  int          t_tgt [N];

  logic [31:0] rng;
  int          exp_idx;
  int          issued;
  int          cycles;
  int          phase;
  int          run_left;
  int          redir_wait;
  int          hold_cnt;
  int          ack_cnt;
  logic        ack_loaded;

  core_frontend #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(8)) u_core_frontend (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // slots the back end really took, seen at the clock edge
  always @(posedge clk) begin
    if (!rst_n) begin
      issued = 0;
    end else begin
      issued = issued + int'(issue_i[0] & issue_valid_o[0])
                      + int'(issue_i[1] & issue_valid_o[1]);
    end
  end

  function automatic logic [31:0] lcg_next();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng >> 16;
  endfunction

  function automatic logic [31:0] enc_3r(logic [16:0] opc, logic [4:0] rk, logic [4:0] rj,
                                         logic [4:0] rd);
    inst_word_u u;
    u.reg_fmt.opcode17 = opc;
    u.reg_fmt.rk       = rk;
    u.reg_fmt.rj       = rj;
    u.reg_fmt.rd       = rd;
    return u;
  endfunction

  function automatic logic [31:0] enc_2ri12(logic [9:0] opc, logic [11:0] imm,
                                            logic [4:0] rj, logic [4:0] rd);
    return {opc, imm, rj, rd};
  endfunction

  function automatic logic [31:0] enc_br(logic [5:0] opc, logic [25:0] offs);
    inst_word_u u;
    u.imm_fmt.opcode6 = opc;
    u.imm_fmt.offs26  = offs;
    return u;
  endfunction

  function automatic logic [31:0] mem_read(logic [31:0] adr);
    logic [31:0] off;
    off = adr - RESET_PC;
    if (off < 32'(4 * N) && off[1:0] == 2'b00) begin
      return t_word[int'(off >> 2)];
    end
    // outside the table the word follows its address
    return ~adr;
  endfunction

  task automatic add_row(input int i, input logic [31:0] word, input op_class_e cls,
                         input logic [4:0] r0, input logic [4:0] r1, input logic [4:0] w,
                         input logic [1:0] ev, input int tgt);
    t_word[i]  = word;
    t_class[i] = cls;
    t_r0[i]    = r0;
    t_r1[i]    = r1;
    t_w[i]     = w;
    t_ev[i]    = ev;
    t_tgt[i]   = tgt;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  // compare one issue slot with its table row, imm is always the low 26 bits
  task automatic check_slot(input int s, input int idx);
    logic [31:0] pc;
    logic [2:0]  cls;
    logic [4:0]  r0;
    logic [4:0]  r1;
    logic [4:0]  w;
    logic [25:0] imm;
    if (s == 0) begin
      pc  = issue0_pc_o;
      cls = issue0_class_o;
      r0  = issue0_r0_o;
      r1  = issue0_r1_o;
      w   = issue0_w_o;
      imm = issue0_imm_o;
    end else begin
      pc  = issue1_pc_o;
      cls = issue1_class_o;
      r0  = issue1_r0_o;
      r1  = issue1_r1_o;
      w   = issue1_w_o;
      imm = issue1_imm_o;
    end
    check_val($sformatf("issue%0d_pc_o", s), pc, RESET_PC + 32'(4 * idx));
    check_val($sformatf("issue%0d_class_o", s), 32'(cls), 32'(t_class[idx]));
    check_val($sformatf("issue%0d_r0_o", s), 32'(r0), 32'(t_r0[idx]));
    check_val($sformatf("issue%0d_r1_o", s), 32'(r1), 32'(t_r1[idx]));
    check_val($sformatf("issue%0d_w_o", s), 32'(w), 32'(t_w[idx]));
    check_val($sformatf("issue%0d_imm_o", s), 32'(imm), 32'(t_word[idx][25:0]));
  endtask

  // take one slot and start the row's event when it has one
  task automatic take_slot(input int s, inout logic [1:0] pick);
    check_slot(s, exp_idx);
    if (phase == PH_RUN && t_ev[exp_idx] == EV_REDIR) begin
      phase      = PH_REDIR;
      redir_wait = 0;
      if (s == 0) begin
        pick[1] = 1'b0;
      end
    end else if (phase == PH_RUN && t_ev[exp_idx] == EV_IDLE) begin
      phase = PH_IDLE_REQ;
      if (s == 0) begin
        pick[1] = 1'b0;
      end
    end
    exp_idx++;
  endtask

  initial begin
    logic [31:0] r;
    logic [1:0]  pick;
    logic        hold_issue;
    rst_n         = 1'b0;
    wb_dat_i      = '0;
    wb_ack_i      = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    wait_i        = 1'b0;
    int_i         = 1'b0;
    issue_i       = 2'b00;
    rng           = 32'hcd127c6d;
    exp_idx       = 0;
    cycles        = 0;
    phase         = PH_RUN;
    run_left      = 0;
    redir_wait    = 0;
    hold_cnt      = 0;
    ack_cnt       = 0;
    ack_loaded    = 1'b0;
    add_row(0,  enc_3r(OPC_ADD_W, 5'd2, 5'd1, 5'd3), OP_ALU_R, 5'd2, 5'd1, 5'd3, EV_NONE, 0);
    add_row(1,  enc_3r(OPC_SUB_W, 5'd5, 5'd3, 5'd4), OP_ALU_R, 5'd5, 5'd3, 5'd4, EV_NONE, 0);
    add_row(2,  enc_2ri12(OPC_ADDI_W, 12'h123, 5'd7, 5'd6), OP_ALU_I, 5'd0, 5'd7, 5'd6,
            EV_NONE, 0);
    add_row(3,  enc_2ri12(OPC_LD_W, 12'h010, 5'd9, 5'd8), OP_LOAD, 5'd0, 5'd9, 5'd8, EV_NONE, 0);
    add_row(4,  enc_2ri12(OPC_ST_W, 12'h7fc, 5'd11, 5'd10), OP_STORE, 5'd10, 5'd11, 5'd0,
            EV_NONE, 0);
    add_row(5,  enc_br(OPC_BEQ, {16'h0040, 5'd12, 5'd13}), OP_BRANCH, 5'd13, 5'd12, 5'd0,
            EV_NONE, 0);
    add_row(6,  enc_br(OPC_BL, 26'h0000100), OP_JUMP_LINK, 5'd0, 5'd0, 5'd1, EV_NONE, 0);
    add_row(7,  32'hffff_ffff, OP_INVALID, 5'd0, 5'd0, 5'd0, EV_NONE, 0);
    // taken branch, rows 9 to 11 must never issue
    add_row(8,  enc_br(OPC_B, 26'h0000010), OP_BRANCH, 5'd0, 5'd0, 5'd0, EV_REDIR, 12);
    add_row(9,  enc_3r(OPC_ADD_W, 5'd9, 5'd9, 5'd9), OP_ALU_R, 5'd9, 5'd9, 5'd9, EV_NONE, 0);
    add_row(10, enc_3r(OPC_ADD_W, 5'd10, 5'd10, 5'd10), OP_ALU_R, 5'd10, 5'd10, 5'd10,
            EV_NONE, 0);
    add_row(11, enc_3r(OPC_ADD_W, 5'd11, 5'd11, 5'd11), OP_ALU_R, 5'd11, 5'd11, 5'd11,
            EV_NONE, 0);
    add_row(12, enc_3r(OPC_ADD_W, 5'd14, 5'd15, 5'd16), OP_ALU_R, 5'd14, 5'd15, 5'd16,
            EV_NONE, 0);
    add_row(13, enc_2ri12(OPC_ADDI_W, 12'hfff, 5'd17, 5'd18), OP_ALU_I, 5'd0, 5'd17, 5'd18,
            EV_NONE, 0);
    add_row(14, enc_3r(OPC_IDLE, 5'd0, 5'd0, 5'd0), OP_IDLE, 5'd0, 5'd0, 5'd0, EV_IDLE, 0);
    add_row(15, enc_2ri12(OPC_LD_W, 12'h004, 5'd19, 5'd20), OP_LOAD, 5'd0, 5'd19, 5'd20,
            EV_NONE, 0);
    add_row(16, 32'h0000_0000, OP_INVALID, 5'd0, 5'd0, 5'd0, EV_NONE, 0);
    add_row(17, enc_br(OPC_BL, 26'h3ffffff), OP_JUMP_LINK, 5'd0, 5'd0, 5'd1, EV_NONE, 0);
    add_row(18, enc_3r(OPC_SUB_W, 5'd21, 5'd22, 5'd23), OP_ALU_R, 5'd21, 5'd22, 5'd23,
            EV_NONE, 0);
    add_row(19, enc_2ri12(OPC_ST_W, 12'h008, 5'd24, 5'd25), OP_STORE, 5'd25, 5'd24, 5'd0,
            EV_NONE, 0);
    add_row(20, enc_br(OPC_BEQ, {16'hffff, 5'd26, 5'd27}), OP_BRANCH, 5'd27, 5'd26, 5'd0,
            EV_NONE, 0);
    add_row(21, enc_3r(OPC_ADD_W, 5'd31, 5'd30, 5'd29), OP_ALU_R, 5'd31, 5'd30, 5'd29,
            EV_NONE, 0);
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    while (exp_idx < N) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("timeout: only %0d instructions issued after %0d cycles", issued, cycles);
        $display("tests failed");
        $fatal(1);
      end
      redirect_i = 1'b0;
      wait_i     = 1'b0;
      int_i      = 1'b0;
      hold_issue = 1'b0;

      // read-only bus
      check_val("wb_we_o", 32'(wb_we_o), 32'd0);

      // memory model, ack after 0 to 2 wait cycles
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
      end else if (wb_cyc_o) begin
        if (!ack_loaded) begin
          ack_cnt    = int'(lcg_next() % 3);
          ack_loaded = 1'b1;
        end
        if (ack_cnt == 0) begin
          wb_ack_i   = 1'b1;
          wb_dat_i   = mem_read(wb_adr_o);
          ack_loaded = 1'b0;
        end else begin
          ack_cnt--;
        end
      end

      case (phase)
        PH_REDIR: begin
          hold_issue = 1'b1;
          redir_wait++;
          // prefer a redirect that lands on an open read
          if ((wb_cyc_o && !wb_ack_i) || redir_wait > 20) begin
            redirect_i    = 1'b1;
            redirect_pc_i = RESET_PC + 32'(4 * t_tgt[exp_idx - 1]);
            exp_idx       = t_tgt[exp_idx - 1];
            phase         = PH_RUN;
          end
        end
        PH_IDLE_REQ: begin
          wait_i = 1'b1;
          phase  = PH_DRAIN;
        end
        PH_DRAIN: begin
          if (!wb_cyc_o) begin
            phase    = PH_HOLD;
            hold_cnt = 0;
          end
        end
        PH_HOLD: begin
          check_val("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
          hold_cnt++;
          if (hold_cnt == HOLD_LEN) begin
            int_i = 1'b1;
            phase = PH_RUN;
          end
        end
        default: ;
      endcase

      // back end picks 00, 01 or 11 with occasional long stalls
      pick = 2'b00;
      if (run_left > 0) begin
        run_left--;
      end else begin
        r = lcg_next();
        case (r[2:0])
          3'd0:      run_left = 10 + int'(r[7:4]);
          3'd1, 3'd2: pick = 2'b01;
          default:   pick = 2'b11;
        endcase
      end
      pick = hold_issue ? 2'b00 : (pick & issue_valid_o);
      if (pick[0]) begin
        take_slot(0, pick);
      end
      if (pick[1] && exp_idx >= N) begin
        pick[1] = 1'b0;
      end
      if (pick[1]) begin
        take_slot(1, pick);
      end
      issue_i = pick;
    end

    // let the last handshake reach the DUT before counting
    @(posedge clk);
    #1;
    check_val("issued count", 32'(issued), 32'(EXP_ISSUED));
    $display("all tests passed");
    $finish;
  end

endmodule

//--- core_frontend.f
hdl/frontend_pkg.sv
hdl/fetch_unit.sv
hdl/frontend_ctrl.sv
hdl/inst_queue.sv
hdl/inst_decoder.sv
hdl/issue_buffer.sv
hdl/core_frontend.sv
verification/core_frontend_checker.sv
verification/core_frontend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_frontend_tb
FILELIST  ?= core_frontend.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
